//--- inverse_stimulus.txt
# columns: four input words of one matrix row, then four expected inverse words, hex, 12 fraction bits
# four rows make one case, lines starting with # are skipped

# identity
001000 000000 000000 000000 001000 000000 000000 000000
000000 001000 000000 000000 000000 001000 000000 000000
000000 000000 001000 000000 000000 000000 001000 000000
000000 000000 000000 001000 000000 000000 000000 001000

# diagonal 4, 16, 0.25, 1
004000 000000 000000 000000 000400 000000 000000 000000
000000 010000 000000 000000 000000 000100 000000 000000
000000 000000 000400 000000 000000 000000 004000 000000
000000 000000 000000 001000 000000 000000 000000 001000

# diagonal 64, 0.0625, 1, 4
040000 000000 000000 000000 000040 000000 000000 000000
000000 000100 000000 000000 000000 010000 000000 000000
000000 000000 001000 000000 000000 000000 001000 000000
000000 000000 000000 004000 000000 000000 000000 000400

# full matrix built from L with rows 2000, 1100, 0120, 1011
004000 002000 000000 002000 001200 fff000 000800 fff400
002000 002000 001000 001000 fff000 001800 fff800 000800
000000 001000 005000 002000 000800 fff800 000800 fff800
002000 001000 002000 003000 fff400 000800 fff800 001000

//--- list.f
+incdir+.
inv_pkg.sv
array_div.sv
isqrt.sv
cholesky.sv
lt_inverse.sv
gram_mult.sv
inverse.sv
inverse_tb.sv

//--- run.sh
#!/bin/sh
# build and run the inverse testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module inverse_tb -f list.f -o sim_inverse
status=$?
if [ "$status" -ne 0 ]; then
	echo "verilator build failed"
	exit "$status"
fi

./obj_dir/sim_inverse
status=$?
if [ "$status" -ne 0 ]; then
	echo "simulation failed"
	exit "$status"
fi

exit 0

//--- inverse_tb.sv
/* testbench for the 4x4 inverse: file-driven cases, structure, round-trip and busy checks */
`timescale 1ns/1ps
`include "inv_macros.svh"

module inverse_tb;
	import inv_pkg::*;

	localparam int TIMEOUT = 4000;
	localparam longint TOL = 4;
	localparam fix_t ONE = fix_t'(1 << `INV_FRAC);

	logic i;
	logic arst_n;
	logic start;
	matrix_t matrix;
	logic done;
	matrix_t l;
	matrix_t l_inv;
	matrix_t inv;

	matrix_t in_q [$];
	matrix_t exp_q [$];

	inverse u_dut (
		.i      (i),
		.arst_n (arst_n),
		.start  (start),
		.matrix (matrix),
		.done   (done),
		.l      (l),
		.l_inv  (l_inv),
		.inv    (inv)
	);

	always #4 i = ~i;

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Regression failed");
		$fatal(1, "stopped at %0t", $time);
	endtask

	task automatic mismatch(input string name, input int r, input int c,
		input longint got, input longint want);
		stop_run($sformatf("FAIL time %0t %s[%0d][%0d] got %0d expected %0d",
			$time, name, r, c, got, want));
	endtask

	// fixed-point product, truncated toward minus infinity
	function automatic longint fmul(input fix_t a, input fix_t b);
		longint p;
		p = longint'(a) * longint'(b);
		return p >>> `INV_FRAC;
	endfunction

	function automatic logic is_diagonal(input matrix_t m);
		logic d;
		d = 1'b1;
		for (int r = 0; r < `INV_N; r++)
			for (int c = 0; c < `INV_N; c++)
				if (r != c && m[r][c] != '0)
					d = 1'b0;
		return d;
	endfunction

	task automatic check_exact(input string name, input int r, input int c,
		input fix_t got, input fix_t want);
		assert (got === want)
		else mismatch(name, r, c, longint'(got), longint'(want));
	endtask

	task automatic check_near(input string name, input int r, input int c,
		input longint got, input longint want);
		longint diff;
		diff = got - want;
		if (diff < 0)
			diff = -diff;
		assert (diff <= TOL)
		else mismatch(name, r, c, got, want);
	endtask

	// four text rows per case, input row then expected inverse row
	task automatic read_stimulus();
		int fd;
		int n;
		int row;
		string line;
		logic [`INV_W-1:0] w [2*`INV_N];
		matrix_t m_in;
		matrix_t m_exp;
		fd = $fopen("inverse_stimulus.txt", "r");
		if (fd == 0)
			stop_run("cannot open inverse_stimulus.txt");
		row = 0;
		while ($fgets(line, fd) != 0) begin
			if (line.len() < 2 || line.getc(0) == "#")
				continue;
			n = $sscanf(line, "%h %h %h %h %h %h %h %h",
				w[0], w[1], w[2], w[3], w[4], w[5], w[6], w[7]);
			if (n != 2 * `INV_N)
				stop_run("malformed line in the stimulus file");
			for (int c = 0; c < `INV_N; c++) begin
				m_in[row][c] = w[c];
				m_exp[row][c] = w[c + `INV_N];
			end
			row++;
			if (row == `INV_N) begin
				in_q.push_back(m_in);
				exp_q.push_back(m_exp);
				row = 0;
			end
		end
		$fclose(fd);
		if (in_q.size() < 2)
			stop_run("stimulus file holds fewer than two cases");
	endtask

	task automatic check_idle();
		assert (done === 1'b0)
		else stop_run("done is not low after reset");
		for (int r = 0; r < `INV_N; r++)
			for (int c = 0; c < `INV_N; c++) begin
				check_exact("l", r, c, l[r][c], fix_t'(0));
				check_exact("l_inv", r, c, l_inv[r][c], fix_t'(0));
				check_exact("inv", r, c, inv[r][c], fix_t'(0));
			end
	endtask

	task automatic apply_start(input matrix_t m);
		@(negedge i);
		matrix = m;
		start = 1'b1;
		@(negedge i);
		start = 1'b0;
	endtask

	task automatic wait_done();
		int n;
		n = 0;
		do begin
			@(negedge i);
			n++;
			if (n > TIMEOUT)
				stop_run("timed out waiting for done");
		end while (!done);
	endtask

	task automatic check_result(input matrix_t a, input matrix_t want);
		longint acc;
		logic diag;
		diag = is_diagonal(a);
		for (int r = 0; r < `INV_N; r++) begin
			assert ($signed(l[r][r]) > 0)
			else stop_run($sformatf("diagonal entry %0d of l is not positive", r));
			for (int c = 0; c < `INV_N; c++) begin
				// upper triangle of both factors stays empty
				if (c > r) begin
					check_exact("l", r, c, l[r][c], fix_t'(0));
					check_exact("l_inv", r, c, l_inv[r][c], fix_t'(0));
				end
				check_exact("inv", r, c, inv[r][c], want[r][c]);
				check_exact("inv_mirror", r, c, inv[r][c], inv[c][r]);
				acc = 0;
				for (int k = 0; k < `INV_N; k++)
					acc += fmul(l[r][k], l[c][k]);
				check_near("l_lt", r, c, acc, longint'($signed(a[r][c])));
				acc = 0;
				for (int k = 0; k < `INV_N; k++)
					acc += fmul(l[r][k], l_inv[k][c]);
				check_near("l_l_inv", r, c, acc, (r == c) ? longint'(ONE) : 0);
			end
			// exact roots and reciprocals on power-of-two diagonals
			if (diag) begin
				check_exact("l_squared", r, r, fix_t'(fmul(l[r][r], l[r][r])), a[r][r]);
				check_exact("l_inv_l", r, r, fix_t'(fmul(l_inv[r][r], l[r][r])), ONE);
			end
		end
	endtask

	task automatic watch_no_done();
		for (int n = 0; n < TIMEOUT; n++) begin
			@(negedge i);
			assert (done === 1'b0)
			else stop_run("a second done followed a start issued while busy");
		end
	endtask

	initial begin
		int last;
		i = 1'b0;
		arst_n = 1'b0;
		start = 1'b0;
		matrix = '0;
		read_stimulus();
		last = in_q.size() - 1;
		repeat (3) @(posedge i);
		@(negedge i);
		check_idle();
		arst_n = 1'b1;
		@(negedge i);
		check_idle();

		for (int n = 0; n < in_q.size(); n++) begin
			apply_start(in_q[n]);
			wait_done();
			check_result(in_q[n], exp_q[n]);
		end

		// start pulse in mid-run is dropped
		apply_start(in_q[last]);
		repeat (5) @(negedge i);
		apply_start(in_q[0]);
		wait_done();
		check_result(in_q[last], exp_q[last]);
		watch_no_done();

		$display("Regression passed");
		$finish;
	end

endmodule

//--- inverse.sv
/* top level: stage sequencer, input latch and shared divider */
`timescale 1ns/1ps

module inverse (
	input  logic             i,
	input  logic             arst_n,
	input  logic             start,
	input  inv_pkg::matrix_t matrix,
	output logic             done,
	output inv_pkg::matrix_t l,
	output inv_pkg::matrix_t l_inv,
	output inv_pkg::matrix_t inv
);
	import inv_pkg::*;

	typedef enum logic [1:0] {ST_CHOL, ST_LTI, ST_MULT} stage_t;

	logic busy;
	stage_t stage;
	matrix_t a_r;
	logic chol_start;
	logic chol_done;
	logic lti_start;
	logic lti_done;
	logic mult_start;
	logic mult_done;
	div_req_t chol_req;
	div_req_t lti_req;
	div_req_t div_req;
	div_rsp_t div_rsp;

	always_ff @(posedge i or negedge arst_n) begin
		if (!arst_n) begin
			busy <= 1'b0;
			stage <= ST_CHOL;
			chol_start <= 1'b0;
			lti_start <= 1'b0;
			mult_start <= 1'b0;
		end else begin
			chol_start <= start && !busy;
			lti_start <= chol_done && stage == ST_CHOL;
			mult_start <= lti_done && stage == ST_LTI;
			if (start && !busy) begin
				busy <= 1'b1;
				stage <= ST_CHOL;
			end else if (chol_done) begin
				stage <= ST_LTI;
			end else if (lti_done) begin
				stage <= ST_MULT;
			end else if (mult_done) begin
				busy <= 1'b0;
			end
		end
	end

	// held for the whole run, a start while busy is dropped
	always_ff @(posedge i) begin
		if (start && !busy)
			a_r <= matrix;
	end

	cholesky u_cholesky (
		.i       (i),
		.arst_n  (arst_n),
		.start   (chol_start),
		.a       (a_r),
		.div_rsp (div_rsp),
		.div_req (chol_req),
		.done    (chol_done),
		.l       (l)
	);

	lt_inverse u_lt_inverse (
		.i       (i),
		.arst_n  (arst_n),
		.start   (lti_start),
		.l       (l),
		.div_rsp (div_rsp),
		.div_req (lti_req),
		.done    (lti_done),
		.l_inv   (l_inv)
	);

	gram_mult u_gram_mult (
		.i      (i),
		.arst_n (arst_n),
		.start  (mult_start),
		.l_inv  (l_inv),
		.done   (mult_done),
		.inv    (inv)
	);

	// idle requester drives all zeros, only one stage is active at a time
	assign div_req = chol_req | lti_req;

	array_div u_array_div (
		.i      (i),
		.arst_n (arst_n),
		.req    (div_req),
		.rsp    (div_rsp)
	);

	assign done = mult_done;

	a_div_share: assert property (@(posedge i) disable iff (!arst_n)
		!(chol_req.valid && lti_req.valid))
		else $error("cholesky and lt_inverse requested the divider together");

endmodule

//--- gram_mult.sv
/* sequential multiply-accumulate forming L^-T * L^-1, upper triangle mirrored */
`timescale 1ns/1ps
`include "inv_macros.svh"

module gram_mult (
	input  logic             i,
	input  logic             arst_n,
	input  logic             start,
	input  inv_pkg::matrix_t l_inv,
	output logic             done,
	output inv_pkg::matrix_t inv
);
	import inv_pkg::*;

	localparam int IW = $clog2(`INV_N);
	localparam logic [IW-1:0] LAST = IW'(`INV_N - 1);

	logic busy;
	logic [IW-1:0] row;
	logic [IW-1:0] col;
	logic [IW-1:0] k;
	fix_t acc;
	fix_t acc_next;
	fix_t prod;
	logic signed [2*`INV_W-1:0] mult_full;

	// column row dotted with column col of L^-1
	assign mult_full = $signed(l_inv[k][row]) * $signed(l_inv[k][col]);
	assign prod = mult_full[`INV_FRAC +: `INV_W];
	assign acc_next = acc + prod;

	always_ff @(posedge i or negedge arst_n) begin
		if (!arst_n) begin
			busy <= 1'b0;
			row <= '0;
			col <= '0;
			k <= '0;
			acc <= '0;
			done <= 1'b0;
			inv <= '0;
		end else begin
			done <= 1'b0;
			if (!busy) begin
				if (start) begin
					busy <= 1'b1;
					row <= '0;
					col <= '0;
					k <= '0;
					acc <= '0;
				end
			end else if (k == LAST) begin
				inv[row][col] <= acc_next;
				inv[col][row] <= acc_next;
				acc <= '0;
				k <= '0;
				if (col == LAST) begin
					if (row == LAST) begin
						busy <= 1'b0;
						done <= 1'b1;
					end else begin
						// next row starts on its diagonal
						row <= row + 1'b1;
						col <= row + 1'b1;
					end
				end else begin
					col <= col + 1'b1;
				end
			end else begin
				acc <= acc_next;
				k <= k + 1'b1;
			end
		end
	end

endmodule

//--- lt_inverse.sv
/* forward substitution giving the inverse of a lower-triangular matrix */
`timescale 1ns/1ps
`include "inv_macros.svh"

module lt_inverse (
	input  logic              i,
	input  logic              arst_n,
	input  logic              start,
	input  inv_pkg::matrix_t  l,
	input  inv_pkg::div_rsp_t div_rsp,
	output inv_pkg::div_req_t div_req,
	output logic              done,
	output inv_pkg::matrix_t  l_inv
);
	import inv_pkg::*;

	localparam int IW = $clog2(`INV_N);
	localparam logic [IW-1:0] LAST = IW'(`INV_N - 1);
	localparam fix_t ONE = fix_t'(1 << `INV_FRAC);

	typedef enum logic [1:0] {S_IDLE, S_ACC, S_DIV} state_t;

	state_t state;
	logic [IW-1:0] row;
	logic [IW-1:0] col;
	logic [IW-1:0] k;
	fix_t acc;
	fix_t prod;
	fix_t num;
	logic signed [2*`INV_W-1:0] mult_full;

	// k runs from col up to row-1 over entries of column col already solved
	assign mult_full = $signed(l[row][k]) * $signed(l_inv[k][col]);
	assign prod = mult_full[`INV_FRAC +: `INV_W];
	assign num = (row == col) ? ONE : -acc;

	always_ff @(posedge i or negedge arst_n) begin
		if (!arst_n) begin
			state <= S_IDLE;
			row <= '0;
			col <= '0;
			k <= '0;
			acc <= '0;
			div_req <= '0;
			done <= 1'b0;
			l_inv <= '0;
		end else begin
			done <= 1'b0;
			div_req <= '0;
			case (state)
				S_IDLE: begin
					if (start) begin
						row <= '0;
						col <= '0;
						k <= '0;
						acc <= '0;
						l_inv <= '0;
						state <= S_ACC;
					end
				end
				S_ACC: begin
					if (k < row) begin
						acc <= acc + prod;
						k <= k + 1'b1;
					end else begin
						div_req.valid <= 1'b1;
						div_req.dividend <= num;
						div_req.divisor <= l[row][row];
						state <= S_DIV;
					end
				end
				default: begin
					if (div_rsp.valid) begin
						l_inv[row][col] <= div_rsp.quotient;
						acc <= '0;
						state <= S_ACC;
						if (row == LAST) begin
							if (col == LAST) begin
								done <= 1'b1;
								state <= S_IDLE;
							end else begin
								col <= col + 1'b1;
								row <= col + 1'b1;
								k <= col + 1'b1;
							end
						end else begin
							row <= row + 1'b1;
							k <= col;
						end
					end
				end
			endcase
		end
	end

endmodule

//--- cholesky.sv
/* column-by-column Cholesky factorization into lower-triangular L */
`timescale 1ns/1ps
`include "inv_macros.svh"

module cholesky (
	input  logic              i,
	input  logic              arst_n,
	input  logic              start,
	input  inv_pkg::matrix_t  a,
	input  inv_pkg::div_rsp_t div_rsp,
	output inv_pkg::div_req_t div_req,
	output logic              done,
	output inv_pkg::matrix_t  l
);
	import inv_pkg::*;

	localparam int IW = $clog2(`INV_N);
	localparam logic [IW-1:0] LAST = IW'(`INV_N - 1);

	typedef enum logic [1:0] {S_IDLE, S_ACC, S_ROOT, S_DIV} state_t;

	state_t state;
	logic [IW-1:0] row;
	logic [IW-1:0] col;
	logic [IW-1:0] k;
	fix_t acc;
	fix_t prod;
	fix_t diff;
	fix_t res;
	logic res_valid;
	logic signed [2*`INV_W-1:0] mult_full;
	logic sqrt_go;
	logic root_valid;
	fix_t radicand;
	fix_t root;

	isqrt u_isqrt (
		.i          (i),
		.arst_n     (arst_n),
		.sqrt_go    (sqrt_go),
		.radicand   (radicand),
		.root_valid (root_valid),
		.root       (root)
	);

	// on the diagonal row == col, so this is the square of l[row][k]
	assign mult_full = $signed(l[row][k]) * $signed(l[col][k]);
	assign prod = mult_full[`INV_FRAC +: `INV_W];
	assign diff = $signed(a[row][col]) - acc;

	assign res_valid = (state == S_ROOT && root_valid) || (state == S_DIV && div_rsp.valid);
	assign res = (state == S_ROOT) ? root : div_rsp.quotient;

	always_ff @(posedge i or negedge arst_n) begin
		if (!arst_n) begin
			state <= S_IDLE;
			row <= '0;
			col <= '0;
			k <= '0;
			acc <= '0;
			sqrt_go <= 1'b0;
			radicand <= '0;
			div_req <= '0;
			done <= 1'b0;
			l <= '0;
		end else begin
			done <= 1'b0;
			sqrt_go <= 1'b0;
			div_req <= '0;
			case (state)
				S_IDLE: begin
					if (start) begin
						row <= '0;
						col <= '0;
						k <= '0;
						acc <= '0;
						l <= '0;
						state <= S_ACC;
					end
				end
				S_ACC: begin
					if (k < col) begin
						acc <= acc + prod;
						k <= k + 1'b1;
					end else if (row == col) begin
						sqrt_go <= 1'b1;
						radicand <= diff;
						state <= S_ROOT;
					end else begin
						div_req.valid <= 1'b1;
						div_req.dividend <= diff;
						div_req.divisor <= l[col][col];
						state <= S_DIV;
					end
				end
				default: begin
					if (res_valid) begin
						l[row][col] <= res;
						acc <= '0;
						k <= '0;
						state <= S_ACC;
						// next row down, or the diagonal of the next column
						if (row == LAST) begin
							if (col == LAST) begin
								done <= 1'b1;
								state <= S_IDLE;
							end else begin
								col <= col + 1'b1;
								row <= col + 1'b1;
							end
						end else begin
							row <= row + 1'b1;
						end
					end
				end
			endcase
		end
	end

endmodule

//--- isqrt.sv
/* iterative non-restoring fixed-point square root, one bit per cycle */
`timescale 1ns/1ps
`include "inv_macros.svh"

module isqrt (
	input  logic          i,
	input  logic          arst_n,
	input  logic          sqrt_go,
	input  inv_pkg::fix_t radicand,
	output logic          root_valid,
	output inv_pkg::fix_t root
);
	localparam int QW = `INV_SQRT_CYCLES;
	localparam int RW = 2 * QW;
	localparam int SW = QW + 4;
	localparam int CW = $clog2(`INV_SQRT_CYCLES);
	localparam logic [CW-1:0] LAST = CW'(`INV_SQRT_CYCLES - 1);

	logic busy;
	logic [CW-1:0] cnt;
	logic [RW-1:0] val;
	logic [QW-1:0] q;
	logic [QW-1:0] q_next;
	logic signed [SW-1:0] rem;
	logic signed [SW-1:0] rem_sh;
	logic signed [SW-1:0] rem_next;

	// bring down two radicand bits, then add or subtract by the sign of rem
	assign rem_sh = {rem[SW-3:0], val[RW-1 -: 2]};
	assign rem_next = rem[SW-1] ? rem_sh + $signed({1'b0, q, 2'b11})
		: rem_sh - $signed({1'b0, q, 2'b01});
	assign q_next = {q[QW-2:0], ~rem_next[SW-1]};

	// last root bit goes out with root_valid
	assign root_valid = busy && cnt == LAST;
	assign root = {{(`INV_W-QW){1'b0}}, q_next};

	always_ff @(posedge i or negedge arst_n) begin
		if (!arst_n) begin
			busy <= 1'b0;
			cnt <= '0;
		end else if (busy) begin
			cnt <= cnt + 1'b1;
			if (cnt == LAST)
				busy <= 1'b0;
		end else if (sqrt_go) begin
			busy <= 1'b1;
			cnt <= '0;
		end
	end

	always_ff @(posedge i) begin
		if (busy) begin
			val <= {val[RW-3:0], 2'b00};
			rem <= rem_next;
			q <= q_next;
		end else if (sqrt_go) begin
			// scale so the root keeps INV_FRAC fraction bits
			val <= {radicand, {`INV_FRAC{1'b0}}};
			rem <= '0;
			q <= '0;
		end
	end

	a_radicand: assert property (@(posedge i) disable iff (!arst_n)
		sqrt_go |-> !radicand[`INV_W-1])
		else $error("negative radicand, matrix not positive definite");

endmodule

//--- array_div.sv
/* iterative signed fixed-point divider, restoring, one quotient bit per cycle */
`timescale 1ns/1ps
`include "inv_macros.svh"

module array_div (
	input  logic              i,
	input  logic              arst_n,
	input  inv_pkg::div_req_t req,
	output inv_pkg::div_rsp_t rsp
);
	import inv_pkg::*;

	localparam int QW = `INV_W + `INV_FRAC;
	localparam int CW = $clog2(`INV_DIV_CYCLES);
	localparam logic [CW-1:0] LAST = CW'(`INV_DIV_CYCLES - 1);

	logic busy;
	logic [CW-1:0] cnt;
	logic neg;
	logic zero;
	logic [QW-1:0] quo;
	logic [QW-1:0] quo_next;
	logic [QW-1:0] q_fin;
	logic [`INV_W-1:0] rem;
	logic [`INV_W-1:0] rem_next;
	logic [`INV_W-1:0] den;
	logic [`INV_W:0] trial;
	logic [`INV_W:0] sub;
	logic fit;

	function automatic logic [`INV_W-1:0] mag(input fix_t x);
		return x[`INV_W-1] ? -x : x;
	endfunction

	// dividend bits shift out of quo while quotient bits shift in
	assign trial = {rem, quo[QW-1]};
	assign sub = trial - {1'b0, den};
	assign fit = trial >= {1'b0, den};
	assign rem_next = fit ? sub[`INV_W-1:0] : trial[`INV_W-1:0];
	assign quo_next = {quo[QW-2:0], fit};
	assign q_fin = neg ? -quo_next : quo_next;

	always_ff @(posedge i or negedge arst_n) begin
		if (!arst_n) begin
			busy <= 1'b0;
			cnt <= '0;
		end else if (busy) begin
			cnt <= cnt + 1'b1;
			if (cnt == LAST)
				busy <= 1'b0;
		end else if (req.valid) begin
			busy <= 1'b1;
			cnt <= '0;
		end
	end

	// last quotient bit goes out with the response
	always_comb begin
		rsp = '0;
		if (busy && cnt == LAST) begin
			rsp.valid = 1'b1;
			// x/0 saturates to the largest magnitude of the right sign
			if (zero)
				rsp.quotient = neg ? {1'b1, {(`INV_W-1){1'b0}}}
					: {1'b0, {(`INV_W-1){1'b1}}};
			else
				rsp.quotient = q_fin[`INV_W-1:0];
		end
	end

	always_ff @(posedge i) begin
		if (busy) begin
			quo <= quo_next;
			rem <= rem_next;
		end else if (req.valid) begin
			quo <= {mag(req.dividend), {`INV_FRAC{1'b0}}};
			rem <= '0;
			den <= mag(req.divisor);
			neg <= req.dividend[`INV_W-1] ^ req.divisor[`INV_W-1];
			zero <= req.divisor == '0;
		end
	end

	a_no_overlap: assert property (@(posedge i) disable iff (!arst_n) req.valid |-> !busy)
		else $error("divider request while busy");
	a_latency: assert property (@(posedge i) disable iff (!arst_n)
		req.valid |-> ##(`INV_DIV_CYCLES) rsp.valid)
		else $error("divider response late or missing");

endmodule

//--- inv_pkg.sv
/* fixed-point word, matrix and divider request/response types */
`include "inv_macros.svh"

package inv_pkg;

	// signed fixed point, INV_FRAC fraction bits
	typedef logic signed [`INV_W-1:0] fix_t;

	// indexed [row][col]
	typedef fix_t [`INV_N-1:0][`INV_N-1:0] matrix_t;

	// all fields zero while valid is low, so requests merge by OR
	typedef struct packed {
		logic valid;
		fix_t dividend;
		fix_t divisor;
	} div_req_t;

	typedef struct packed {
		logic valid;
		fix_t quotient;
	} div_rsp_t;

endpackage

//--- inv_macros.svh
/* fixed-point format, matrix order and unit latencies for the 4x4 inverse */
`ifndef INV_MACROS_SVH
`define INV_MACROS_SVH

// matrix order
`define INV_N 4

// word width and fraction bits of every matrix entry
`define INV_W 24
`define INV_FRAC 12

// one quotient bit per cycle over the pre-shifted dividend
`define INV_DIV_CYCLES (`INV_W + `INV_FRAC)

// one root bit per cycle
`define INV_SQRT_CYCLES 18

`endif
